// File: verilog/fetch_pkg.sv
// Fetch address definitions

`default_nettype none

package fetch_pkg;

    // ------------------------------------------------------------------------
    // Address split
    // ------------------------------------------------------------------------

    localparam int ADDR_W   = 32;
    localparam int OFFSET_W = 2;
    localparam int INDEX_W  = 3;
    localparam int TAG_W    = 27;
    localparam int NUM_SETS = 8;

    // Index sits right above the byte offset, tag above the index
    localparam int INDEX_LSB = OFFSET_W;
    localparam int TAG_LSB   = OFFSET_W + INDEX_W;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    // Sequential fetch step
    localparam addr_t INSTR_BYTES = 32'd4;

    // ------------------------------------------------------------------------
    // Two-bit saturating counter
    // ------------------------------------------------------------------------

    localparam int CTR_W = 2;

    typedef logic [CTR_W-1:0] ctr_t;

    // Upper bit set means predict taken
    localparam ctr_t CTR_SNT = 2'd0;
    localparam ctr_t CTR_WNT = 2'd1;
    localparam ctr_t CTR_WT  = 2'd2;
    localparam ctr_t CTR_ST  = 2'd3;

    // ------------------------------------------------------------------------
    // BTB entry and set
    // ------------------------------------------------------------------------

    localparam int NUM_WAYS = 2;
    localparam int SPARE_W  = 2;
    localparam int SET_W    = 128;

    // 64-bit entry, spare bits stay zero
    typedef struct packed {
        logic               valid;
        tag_t               tag;
        addr_t              target;
        ctr_t               ctr;
        logic [SPARE_W-1:0] spare;
    } btb_entry_t;

    // One storage word seen either raw or as two ways
    // Way 0 is the upper half
    typedef union packed {
        logic [SET_W-1:0]              raw;
        btb_entry_t [0:NUM_WAYS-1]     ways;
    } btb_set_u;

    // Set index of a byte address
    function automatic index_t pc_index(input addr_t a);
        return a[INDEX_LSB +: INDEX_W];
    endfunction

    // Tag of a byte address
    function automatic tag_t pc_tag(input addr_t a);
        return a[TAG_LSB +: TAG_W];
    endfunction

endpackage

`default_nettype wire

// File: verilog/btb_port_if.sv
// BTB update port

`timescale 1ns/1ps
`default_nettype none

interface btb_port_if import fetch_pkg::*; ();

    // Update read side
    index_t   upd_index;
    btb_set_u upd_set;
    logic     upd_lru;

    // Registered set write
    logic     wr_en;
    index_t   wr_index;
    btb_set_u wr_set;

    // LRU write for the update index
    logic     lru_wr_en;
    logic     lru_wr_val;

    // Update stage side
    modport upd (
        output upd_index, wr_en, wr_index, wr_set, lru_wr_en, lru_wr_val,
        input  upd_set, upd_lru
    );

    // Storage side
    modport arr (
        input  upd_index, wr_en, wr_index, wr_set, lru_wr_en, lru_wr_val,
        output upd_set, upd_lru
    );

endinterface

`default_nettype wire

// File: verilog/btb_update_stage.sv
// BTB training stage

`timescale 1ns/1ps
`default_nettype none

module btb_update_stage
    import fetch_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    update_valid,
    input  logic    update_taken,
    input  addr_t   update_pc,
    input  addr_t   update_target,
    btb_port_if.upd port
);

    // Saturating step toward the resolved outcome
    function automatic ctr_t ctr_step(input ctr_t cur, input logic taken);
        ctr_t nxt;
        case (cur)
            CTR_SNT: nxt = taken ? CTR_WNT : CTR_SNT;
            CTR_WNT: nxt = taken ? CTR_WT  : CTR_SNT;
            CTR_WT:  nxt = taken ? CTR_ST  : CTR_WNT;
            default: nxt = taken ? CTR_ST  : CTR_WT;
        endcase
        return nxt;
    endfunction

    index_t     upd_idx;
    tag_t       upd_tag;
    btb_set_u   src_set;
    btb_set_u   merged_set;
    logic [1:0] tag_hit;
    logic       entry_exists;
    logic       ins_way;
    ctr_t       old_ctr;
    ctr_t       new_ctr;

    // Pending write, one cycle behind the update
    logic       wr_en_q;
    index_t     wr_index_q;
    btb_set_u   wr_set_q;

    assign upd_idx = pc_index(update_pc);
    assign upd_tag = pc_tag(update_pc);

    // Stored set for this index comes back from the array
    assign port.upd_index = upd_idx;

    // ------------------------------------------------------------------------
    // Merge
    // ------------------------------------------------------------------------

    always_comb begin
        // A write still in flight to this set is newer than storage
        if (wr_en_q && (wr_index_q == upd_idx)) begin
            src_set = wr_set_q;
        end else begin
            src_set = port.upd_set;
        end

        // Look for the branch in both ways
        for (int w = 0; w < NUM_WAYS; w++) begin
            tag_hit[w] = src_set.ways[w].valid && (src_set.ways[w].tag == upd_tag);
        end
        entry_exists = |tag_hit;

        // Matching way, else the LRU victim
        // LRU bit 1 names way 0
        if (entry_exists) begin
            ins_way = tag_hit[1];
        end else begin
            ins_way = ~port.upd_lru;
        end

        // New branches start strongly not taken before the step
        if (entry_exists) begin
            old_ctr = src_set.ways[ins_way].ctr;
        end else begin
            old_ctr = CTR_SNT;
        end
        new_ctr = ctr_step(old_ctr, update_taken);

        // Other way passes through untouched
        merged_set = src_set;
        merged_set.ways[ins_way].valid  = 1'b1;
        merged_set.ways[ins_way].tag    = upd_tag;
        merged_set.ways[ins_way].target = update_target;
        merged_set.ways[ins_way].ctr    = new_ctr;
        merged_set.ways[ins_way].spare  = '0;
    end

    // Insert flips the victim to the way not just filled
    // Hits on existing entries leave LRU alone
    assign port.lru_wr_en  = update_valid && !entry_exists;
    assign port.lru_wr_val = ins_way;

    // ------------------------------------------------------------------------
    // Write register
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= update_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (update_valid) begin
            wr_index_q <= upd_idx;
            wr_set_q   <= merged_set;
        end
    end

    assign port.wr_en    = wr_en_q;
    assign port.wr_index = wr_index_q;
    assign port.wr_set   = wr_set_q;

    // Stored set and LRU seen by a training strobe are always known
    a_src_known: assert property (
        @(posedge clk) disable iff (rst)
        update_valid |-> !$isunknown({src_set.raw, port.upd_lru})
    );

endmodule

`default_nettype wire

// File: verilog/btb_array.sv
// BTB storage and lookup

`timescale 1ns/1ps
`default_nettype none

module btb_array
    import fetch_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  addr_t   pc,
    btb_port_if.arr port,
    output logic    hit,
    output logic    hit_taken,
    output addr_t   hit_target
);

    // Raw set words
    logic [SET_W-1:0]    mem [NUM_SETS];

    // One LRU bit per set
    logic [NUM_SETS-1:0] lru_q;
    logic [NUM_SETS-1:0] lru_d;

    index_t     rd_idx;
    tag_t       rd_tag;
    btb_set_u   rd_set;
    logic [1:0] way_hit;
    ctr_t       hit_ctr;

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                mem[i] <= '0;
            end
        end else if (port.wr_en) begin
            mem[port.wr_index] <= port.wr_set.raw;
        end
    end

    // Update side read, no forwarding here
    assign port.upd_set.raw = mem[port.upd_index];
    assign port.upd_lru     = lru_q[port.upd_index];

    // ------------------------------------------------------------------------
    // Lookup
    // ------------------------------------------------------------------------

    assign rd_idx = pc_index(pc);
    assign rd_tag = pc_tag(pc);

    always_comb begin
        // Write landing this cycle is seen right away
        if (port.wr_en && (port.wr_index == rd_idx)) begin
            rd_set.raw = port.wr_set.raw;
        end else begin
            rd_set.raw = mem[rd_idx];
        end

        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = rd_set.ways[w].valid && (rd_set.ways[w].tag == rd_tag);
        end

        hit = |way_hit;

        // Way 0 first, duplicates do not occur
        if (way_hit[0]) begin
            hit_ctr    = rd_set.ways[0].ctr;
            hit_target = rd_set.ways[0].target;
        end else if (way_hit[1]) begin
            hit_ctr    = rd_set.ways[1].ctr;
            hit_target = rd_set.ways[1].target;
        end else begin
            hit_ctr    = CTR_SNT;
            hit_target = rd_set.ways[1].target;
        end

        // Upper counter bit
        hit_taken = hit_ctr[CTR_W-1];
    end

    // ------------------------------------------------------------------------
    // LRU
    // ------------------------------------------------------------------------

    always_comb begin
        lru_d = lru_q;

        // Hit in way 1 makes way 0 the victim and the other way round
        if (hit) begin
            lru_d[rd_idx] = way_hit[1];
        end

        // Update applied last so it wins on a shared set
        if (port.lru_wr_en) begin
            lru_d[port.upd_index] = port.lru_wr_val;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lru_q <= '0;
        end else begin
            lru_q <= lru_d;
        end
    end

    // Storage, forwarding and PC all settle to known values
    a_hit_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(hit)
    );

endmodule

`default_nettype wire

// File: verilog/pc_select.sv
// Program counter and next PC

`timescale 1ns/1ps
`default_nettype none

module pc_select
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  pc_en,
    input  logic  redirect_valid,
    input  logic  hit,
    input  logic  hit_taken,
    input  addr_t redirect_pc,
    input  addr_t hit_target,
    output addr_t pc,
    output addr_t pred_target,
    output logic  pred_taken
);

    addr_t next_pc;

    // ------------------------------------------------------------------------
    // Prediction
    // ------------------------------------------------------------------------

    // Only a hit with a taken counter steers fetch
    assign pred_taken = hit && hit_taken;

    // Fall through when not predicted taken
    assign pred_target = pred_taken ? hit_target : pc + INSTR_BYTES;

    // Execute redirect beats any prediction
    assign next_pc = redirect_valid ? redirect_pc : pred_target;

    // ------------------------------------------------------------------------
    // PC register
    // ------------------------------------------------------------------------

    // Stall holds the current PC
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (pc_en) begin
            pc <= next_pc;
        end
    end

    // Redirects and stored targets keep fetch on word boundaries
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (rst)
        pc[OFFSET_W-1:0] == '0
    );

endmodule

`default_nettype wire

// File: verilog/fetch_top.sv
// Fetch address top

`timescale 1ns/1ps
`default_nettype none

module fetch_top
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  pc_en,
    input  logic  redirect_valid,
    input  addr_t redirect_pc,
    input  logic  update_valid,
    input  logic  update_taken,
    input  addr_t update_pc,
    input  addr_t update_target,
    output addr_t pc,
    output logic  pred_taken,
    output addr_t pred_target
);

    // Lookup result from the array
    logic  hit;
    logic  hit_taken;
    addr_t hit_target;

    // Update stage to array link
    btb_port_if u_port ();

    // Training from resolved branches
    btb_update_stage u_update (
        .clk           (clk),
        .rst           (rst),
        .update_valid  (update_valid),
        .update_taken  (update_taken),
        .update_pc     (update_pc),
        .update_target (update_target),
        .port          (u_port)
    );

    // Sets, LRU and lookup on the current PC
    btb_array u_array (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .port       (u_port),
        .hit        (hit),
        .hit_taken  (hit_taken),
        .hit_target (hit_target)
    );

    // PC register and next PC choice
    pc_select u_pc (
        .clk            (clk),
        .rst            (rst),
        .pc_en          (pc_en),
        .redirect_valid (redirect_valid),
        .hit            (hit),
        .hit_taken      (hit_taken),
        .redirect_pc    (redirect_pc),
        .hit_target     (hit_target),
        .pc             (pc),
        .pred_target    (pred_target),
        .pred_taken     (pred_taken)
    );

endmodule

`default_nettype wire

// File: dv/fetch_tests.svh
// Directed fetch tests

// One or more cycles of the same training strobe, model follows
task automatic send_update(input addr_t a, input addr_t t, input logic taken, input int n);
    @(posedge clk);
    update_valid  <= 1'b1;
    update_pc     <= a;
    update_target <= t;
    update_taken  <= taken;
    repeat (n) @(posedge clk);
    update_valid <= 1'b0;
    repeat (n) model_update(a, t, taken);
endtask

// Redirect once, then stall so the PC stays put
task automatic place_pc(input addr_t a);
    int n;
    @(posedge clk);
    redirect_valid <= 1'b1;
    redirect_pc    <= a;
    pc_en          <= 1'b1;
    @(posedge clk);
    redirect_valid <= 1'b0;
    pc_en          <= 1'b0;
    n = 0;
    do begin
        @(negedge clk);
        n++;
    end while ((pc !== a) && (n < 10));
    if (pc !== a) begin
        $display("ERROR pc never reached %h after a redirect", a);
        $display("Simulation FAILED");
        $finish;
    end
endtask

// Set 7 holds no branch
task automatic park();
    place_pc(32'h0000_F01C);
endtask

// Expected prediction from the model, hit also touches model LRU
task automatic expect_lookup(input string name, input addr_t a);
    int    idx;
    logic  taken;
    addr_t tgt;
    idx   = a[4:2];
    taken = 1'b0;
    tgt   = a + 32'd4;
    for (int w = 0; w < 2; w++) begin
        if (m_valid[idx][w] && (m_tag[idx][w] == a[31:5])) begin
            taken      = m_ctr[idx][w][1];
            tgt        = taken ? m_tgt[idx][w] : a + 32'd4;
            m_lru[idx] = (w == 1);
        end
    end
    @(negedge clk);
    check_val({name, " pc"}, a, pc);
    check_val({name, " taken"}, taken, pred_taken);
    check_val({name, " target"}, tgt, pred_target);
endtask

task automatic test_reset_seq();
    int e0;
    e0 = errors;
    @(negedge clk);
    check_val("reset pc", 32'd0, pc);
    check_val("reset taken", 32'd0, pred_taken);
    @(posedge clk);
    pc_en <= 1'b1;
    for (int i = 1; i <= 4; i++) begin
        @(posedge clk);
        @(negedge clk);
        check_val("seq pc", i * 4, pc);
    end
    // One more step lands before the stall takes hold
    @(posedge clk);
    pc_en <= 1'b0;
    repeat (3) begin
        @(negedge clk);
        check_val("stall pc", 32'd20, pc);
    end
    finish_test("reset_seq", e0);
endtask

task automatic test_redirect();
    int    e0;
    addr_t br;
    addr_t dest;
    e0   = errors;
    br   = 32'h0000_7004;
    dest = 32'h0000_0800;
    park();
    send_update(br, rand_target(), 1'b1, 2);
    place_pc(br);
    expect_lookup("redirect lookup", br);
    // Prediction and redirect both present, redirect must win
    @(posedge clk);
    redirect_valid <= 1'b1;
    redirect_pc    <= dest;
    pc_en          <= 1'b1;
    @(posedge clk);
    redirect_valid <= 1'b0;
    pc_en          <= 1'b0;
    @(negedge clk);
    check_val("redirect pc", dest, pc);
    finish_test("redirect", e0);
endtask

task automatic test_warmup();
    int    e0;
    addr_t a;
    addr_t t;
    e0 = errors;
    a  = 32'h0000_5010;
    t  = rand_target();
    park();
    send_update(a, t, 1'b1, 1);
    place_pc(a);
    expect_lookup("warmup one", a);
    check_val("warmup one taken", 32'd0, pred_taken);
    check_val("warmup one target", a + 32'd4, pred_target);
    park();
    send_update(a, t, 1'b1, 1);
    place_pc(a);
    expect_lookup("warmup two", a);
    check_val("warmup two target", t, pred_target);
    // Let fetch follow the prediction for one step
    @(posedge clk);
    pc_en <= 1'b1;
    @(posedge clk);
    pc_en <= 1'b0;
    @(negedge clk);
    check_val("warmup next pc", t, pc);
    finish_test("warmup", e0);
endtask

task automatic test_hysteresis();
    int    e0;
    addr_t a;
    addr_t t;
    e0 = errors;
    a  = 32'h0000_400C;
    t  = rand_target();
    park();
    send_update(a, t, 1'b1, 3);
    send_update(a, t, 1'b0, 1);
    place_pc(a);
    expect_lookup("hyst one", a);
    check_val("hyst one taken", 32'd1, pred_taken);
    park();
    send_update(a, t, 1'b0, 1);
    place_pc(a);
    expect_lookup("hyst two", a);
    check_val("hyst two taken", 32'd0, pred_taken);
    finish_test("hysteresis", e0);
endtask

task automatic test_replace();
    int    e0;
    int    n_taken;
    addr_t a1;
    addr_t a2;
    addr_t a3;
    e0 = errors;
    // Same set 2, three different tags
    a1 = 32'h0000_1008;
    a2 = 32'h0000_2008;
    a3 = 32'h0000_3008;
    park();
    send_update(a1, rand_target(), 1'b1, 2);
    send_update(a2, rand_target(), 1'b1, 2);
    send_update(a3, rand_target(), 1'b1, 2);
    place_pc(a1);
    expect_lookup("replace a1", a1);
    n_taken = pred_taken;
    place_pc(a2);
    expect_lookup("replace a2", a2);
    n_taken += pred_taken;
    place_pc(a3);
    expect_lookup("replace a3", a3);
    check_val("replace a3 taken", 32'd1, pred_taken);
    check_val("replace survivors", 32'd1, n_taken);
    finish_test("replace", e0);
endtask

task automatic test_back_to_back();
    int    e0;
    addr_t a;
    e0 = errors;
    a  = 32'h0000_6014;
    park();
    // Second strobe merges into the still pending first write
    send_update(a, rand_target(), 1'b1, 2);
    place_pc(a);
    expect_lookup("b2b lookup", a);
    check_val("b2b taken", 32'd1, pred_taken);
    finish_test("back2back", e0);
endtask

// File: dv/fetch_tb.sv
// Fetch address testbench

`timescale 1ns/1ps
`default_nettype none

module fetch_tb
    import fetch_pkg::*;
();

    logic  clk;
    logic  rst;
    logic  pc_en;
    logic  redirect_valid;
    addr_t redirect_pc;
    logic  update_valid;
    logic  update_taken;
    addr_t update_pc;
    addr_t update_target;
    addr_t pc;
    logic  pred_taken;
    addr_t pred_target;

    int errors;
    int tests_run;

    // Reference BTB, indexed by set then way
    logic        m_valid [8][2];
    logic [26:0] m_tag   [8][2];
    addr_t       m_tgt   [8][2];
    logic [1:0]  m_ctr   [8][2];
    // LRU bit of 1 names way 0 as victim
    logic        m_lru   [8];

    fetch_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Checking and reference model
    // ------------------------------------------------------------------------

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // Saturating move toward the outcome
    function automatic logic [1:0] ctr_next(input logic [1:0] c, input logic taken);
        if (taken) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    task automatic model_update(input addr_t a, input addr_t t, input logic taken);
        int idx;
        int w;
        idx = a[4:2];
        w   = -1;
        for (int i = 0; i < 2; i++) begin
            if (m_valid[idx][i] && (m_tag[idx][i] == a[31:5])) begin
                w = i;
            end
        end
        // New branch goes to the victim, LRU then names the other way
        if (w < 0) begin
            w = m_lru[idx] ? 0 : 1;
            m_valid[idx][w] = 1'b1;
            m_tag[idx][w]   = a[31:5];
            m_ctr[idx][w]   = 2'd0;
            m_lru[idx]      = (w == 1);
        end
        m_ctr[idx][w] = ctr_next(m_ctr[idx][w], taken);
        m_tgt[idx][w] = t;
    endtask

    // Word aligned random address
    function automatic addr_t rand_target();
        addr_t t;
        t      = $urandom;
        t[1:0] = 2'b00;
        return t;
    endfunction

    task automatic finish_test(input string name, input int e0);
        tests_run++;
        $display("test %-10s %s", name, (errors == e0) ? "ok" : "had errors");
    endtask

    `include "fetch_tests.svh"

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        void'($urandom(55));
        errors         = 0;
        tests_run      = 0;
        rst            = 1'b1;
        pc_en          = 1'b0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        update_valid   = 1'b0;
        update_taken   = 1'b0;
        update_pc      = '0;
        update_target  = '0;
        for (int s = 0; s < 8; s++) begin
            m_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w]   = '0;
                m_tgt[s][w]   = '0;
                m_ctr[s][w]   = 2'd0;
            end
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        test_reset_seq();
        test_redirect();
        test_warmup();
        test_hysteresis();
        test_replace();
        test_back_to_back();

        $display("Done: %0d tests, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+dv
verilog/fetch_pkg.sv
verilog/btb_port_if.sv
verilog/btb_update_stage.sv
verilog/btb_array.sv
verilog/pc_select.sv
verilog/fetch_top.sv
dv/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_addr

sources:
  # Design
  - files:
      - verilog/fetch_pkg.sv
      - verilog/btb_port_if.sv
      - verilog/btb_update_stage.sv
      - verilog/btb_array.sv
      - verilog/pc_select.sv
      - verilog/fetch_top.sv

  # Testbench
  - target: test
    include_dirs:
      - dv
    files:
      - dv/fetch_tb.sv
